//--- design/icache_defs.svh
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// fetch address and instruction word
`define ICACHE_ADDR_W 32
`define ICACHE_DATA_W 32

// two ways of 16 sets
`define ICACHE_SETS 16
`define ICACHE_INDEX_W 4

// eight words per line, also the burst length
`define ICACHE_LINE_WORDS 8
`define ICACHE_WOFS_W 3

// byte within a word, ignored by lookup
`define ICACHE_BOFS_W 2

`define ICACHE_TAG_W \
    (`ICACHE_ADDR_W - `ICACHE_INDEX_W - `ICACHE_WOFS_W - `ICACHE_BOFS_W)

`endif

//--- design/icache_pkg.sv
`include "icache_defs.svh"

package icache_pkg;

    // fetch address split, msb first
    typedef struct packed {
        logic [`ICACHE_TAG_W-1:0]   tag;
        logic [`ICACHE_INDEX_W-1:0] index;
        logic [`ICACHE_WOFS_W-1:0]  wofs;
        logic [`ICACHE_BOFS_W-1:0]  bofs;
    } icache_addr_fields_t;

    // same word seen raw or by field
    typedef union packed {
        logic [`ICACHE_ADDR_W-1:0] raw;
        icache_addr_fields_t       fields;
    } icache_addr_u;

endpackage

//--- design/icache_tag_array.sv
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_tag_array
    import icache_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  icache_addr_u addr,
    input  logic         install,
    output logic         hit,
    output logic         hit_way,
    output logic         victim_way
);

    logic [`ICACHE_SETS-1:0]  valid_w0;
    logic [`ICACHE_SETS-1:0]  valid_w1;
    logic [`ICACHE_SETS-1:0]  victim;
    logic [`ICACHE_TAG_W-1:0] tag_w0 [`ICACHE_SETS];
    logic [`ICACHE_TAG_W-1:0] tag_w1 [`ICACHE_SETS];
    logic                     hit_w0;
    logic                     hit_w1;

    // compare both ways of the addressed set
    assign hit_w0 = valid_w0[addr.fields.index] &&
                    (tag_w0[addr.fields.index] == addr.fields.tag);
    assign hit_w1 = valid_w1[addr.fields.index] &&
                    (tag_w1[addr.fields.index] == addr.fields.tag);

    assign hit        = hit_w0 || hit_w1;
    assign hit_way    = hit_w1;
    assign victim_way = victim[addr.fields.index];

    // valid and victim bits, flipped per refill
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_w0 <= '0;
            valid_w1 <= '0;
            victim   <= '0;
        end else if (install) begin
            if (victim_way) begin
                valid_w1[addr.fields.index] <= 1'b1;
            end else begin
                valid_w0[addr.fields.index] <= 1'b1;
            end
            victim[addr.fields.index] <= ~victim_way;
        end
    end

    // tag storage
    always_ff @(posedge clk) begin
        if (install) begin
            if (victim_way) begin
                tag_w1[addr.fields.index] <= addr.fields.tag;
            end else begin
                tag_w0[addr.fields.index] <= addr.fields.tag;
            end
        end
    end

endmodule

//--- design/icache_data_array.sv
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_data_array
    import icache_pkg::*;
(
    input  logic                      clk,
    input  icache_addr_u              addr,
    input  logic                      hit_way,
    input  logic                      victim_way,
    input  logic                      beat_we,
    input  logic [`ICACHE_WOFS_W-1:0] beat_idx,
    input  logic [`ICACHE_DATA_W-1:0] beat_data,
    output logic [`ICACHE_DATA_W-1:0] rd_word
);

    // one word per way, set and line position
    logic [`ICACHE_DATA_W-1:0] mem_w0 [`ICACHE_SETS][`ICACHE_LINE_WORDS];
    logic [`ICACHE_DATA_W-1:0] mem_w1 [`ICACHE_SETS][`ICACHE_LINE_WORDS];

    // refill beats land in the victim way
    always_ff @(posedge clk) begin
        if (beat_we) begin
            if (victim_way) begin
                mem_w1[addr.fields.index][beat_idx] <= beat_data;
            end else begin
                mem_w0[addr.fields.index][beat_idx] <= beat_data;
            end
        end
    end

    // hit path read
    always_comb begin
        if (hit_way) begin
            rd_word = mem_w1[addr.fields.index][addr.fields.wofs];
        end else begin
            rd_word = mem_w0[addr.fields.index][addr.fields.wofs];
        end
    end

endmodule

//--- design/icache_refill.sv
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_refill
    import icache_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  icache_addr_u              addr,
    input  logic                      refill_start,
    input  logic                      arready,
    input  logic                      rvalid,
    input  logic [`ICACHE_DATA_W-1:0] rdata,
    input  logic                      rlast,
    output logic                      arvalid,
    output logic [`ICACHE_ADDR_W-1:0] araddr,
    output logic                      rready,
    output logic                      beat_we,
    output logic [`ICACHE_WOFS_W-1:0] beat_idx,
    output logic [`ICACHE_DATA_W-1:0] beat_data,
    output logic                      crit_valid,
    output logic [`ICACHE_DATA_W-1:0] crit_data,
    output logic                      refill_done
);

    logic [`ICACHE_WOFS_W-1:0] beat_cnt;

    // address phase, held until arready
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arvalid <= 1'b0;
        end else if (refill_start) begin
            arvalid <= 1'b1;
        end else if (arvalid && arready) begin
            arvalid <= 1'b0;
        end
    end

    // line-aligned burst address
    always_ff @(posedge clk) begin
        if (refill_start) begin
            araddr <= {addr.fields.tag, addr.fields.index,
                       {(`ICACHE_WOFS_W + `ICACHE_BOFS_W){1'b0}}};
        end
    end

    // data phase from AR handshake to last beat
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rready <= 1'b0;
        end else if (arvalid && arready) begin
            rready <= 1'b1;
        end else if (refill_done) begin
            rready <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
        end else if (refill_start) begin
            beat_cnt <= '0;
        end else if (beat_we) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    assign beat_we   = rvalid && rready;
    assign beat_idx  = beat_cnt;
    assign beat_data = rdata;

    // requested word goes straight back to control
    assign crit_valid  = beat_we && (beat_cnt == addr.fields.wofs);
    assign crit_data   = rdata;
    assign refill_done = beat_we && rlast;

endmodule

//--- design/icache_ctrl.sv
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_ctrl
    import icache_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      req_valid,
    input  logic [`ICACHE_ADDR_W-1:0] req_addr,
    input  logic                      hit,
    input  logic [`ICACHE_DATA_W-1:0] rd_word,
    input  logic                      crit_valid,
    input  logic [`ICACHE_DATA_W-1:0] crit_data,
    input  logic                      refill_done,
    output logic                      resp_ready,
    output logic                      resp_valid,
    output logic [`ICACHE_DATA_W-1:0] resp_data,
    output icache_addr_u              addr,
    output logic                      refill_start
);

    localparam logic [1:0] S_IDLE   = 2'd0;
    localparam logic [1:0] S_LOOKUP = 2'd1;
    localparam logic [1:0] S_REFILL = 2'd2;

    logic [1:0]                state;
    logic [1:0]                state_nxt;
    logic                      accept;
    logic                      lookup_q;
    logic                      hit_q;
    logic [`ICACHE_DATA_W-1:0] word_q;
    logic                      hit_resp;

    assign resp_ready = (state == S_IDLE);
    assign accept     = req_valid && resp_ready;

    // lookup spans two cycles, compare then decide
    assign hit_resp     = (state == S_LOOKUP) && lookup_q && hit_q;
    assign refill_start = (state == S_LOOKUP) && lookup_q && !hit_q;

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE: begin
                if (accept) begin
                    state_nxt = S_LOOKUP;
                end
            end
            S_LOOKUP: begin
                if (lookup_q) begin
                    state_nxt = hit_q ? S_IDLE : S_REFILL;
                end
            end
            S_REFILL: begin
                if (refill_done) begin
                    state_nxt = S_IDLE;
                end
            end
            default: begin
                state_nxt = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            lookup_q <= 1'b0;
            hit_q    <= 1'b0;
        end else begin
            state    <= state_nxt;
            lookup_q <= (state == S_LOOKUP) && !lookup_q;
            if ((state == S_LOOKUP) && !lookup_q) begin
                hit_q <= hit;
            end
        end
    end

    // request latch and lookup stage word
    always_ff @(posedge clk) begin
        if (accept) begin
            addr.raw <= req_addr;
        end
        if ((state == S_LOOKUP) && !lookup_q) begin
            word_q <= rd_word;
        end
    end

    // response, one pulse per request
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= hit_resp || ((state == S_REFILL) && crit_valid);
        end
    end

    always_ff @(posedge clk) begin
        if (hit_resp) begin
            resp_data <= word_q;
        end else if ((state == S_REFILL) && crit_valid) begin
            resp_data <= crit_data;
        end
    end

endmodule

//--- design/icache_top.sv
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_top
    import icache_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      req_valid,
    input  logic [`ICACHE_ADDR_W-1:0] req_addr,
    output logic                      resp_ready,
    output logic                      resp_valid,
    output logic [`ICACHE_DATA_W-1:0] resp_data,
    output logic                      arvalid,
    output logic [`ICACHE_ADDR_W-1:0] araddr,
    input  logic                      arready,
    input  logic                      rvalid,
    input  logic [`ICACHE_DATA_W-1:0] rdata,
    input  logic                      rlast,
    output logic                      rready
);

    icache_addr_u              addr;
    logic                      refill_start;
    logic                      hit;
    logic                      hit_way;
    logic                      victim_way;
    logic                      beat_we;
    logic [`ICACHE_WOFS_W-1:0] beat_idx;
    logic [`ICACHE_DATA_W-1:0] beat_data;
    logic                      crit_valid;
    logic [`ICACHE_DATA_W-1:0] crit_data;
    logic                      refill_done;
    logic [`ICACHE_DATA_W-1:0] rd_word;

    icache_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid    (req_valid),
        .req_addr     (req_addr),
        .hit          (hit),
        .rd_word      (rd_word),
        .crit_valid   (crit_valid),
        .crit_data    (crit_data),
        .refill_done  (refill_done),
        .resp_ready   (resp_ready),
        .resp_valid   (resp_valid),
        .resp_data    (resp_data),
        .addr         (addr),
        .refill_start (refill_start)
    );

    // the tag update and victim flip happen on the last beat
    icache_tag_array u_tag_array (
        .clk        (clk),
        .rst_n      (rst_n),
        .addr       (addr),
        .install    (refill_done),
        .hit        (hit),
        .hit_way    (hit_way),
        .victim_way (victim_way)
    );

    icache_data_array u_data_array (
        .clk        (clk),
        .addr       (addr),
        .hit_way    (hit_way),
        .victim_way (victim_way),
        .beat_we    (beat_we),
        .beat_idx   (beat_idx),
        .beat_data  (beat_data),
        .rd_word    (rd_word)
    );

    icache_refill u_refill (
        .clk          (clk),
        .rst_n        (rst_n),
        .addr         (addr),
        .refill_start (refill_start),
        .arready      (arready),
        .rvalid       (rvalid),
        .rdata        (rdata),
        .rlast        (rlast),
        .arvalid      (arvalid),
        .araddr       (araddr),
        .rready       (rready),
        .beat_we      (beat_we),
        .beat_idx     (beat_idx),
        .beat_data    (beat_data),
        .crit_valid   (crit_valid),
        .crit_data    (crit_data),
        .refill_done  (refill_done)
    );

endmodule

//--- test/axi_mem_model.sv
`timescale 1ns/1ps
`include "icache_defs.svh"

module axi_mem_model #(
    parameter logic [`ICACHE_DATA_W-1:0] DATA_MULT = 32'h9E37_79B1,
    parameter logic [31:0]               SEED      = 32'd91171
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      stall_en,
    input  logic                      arvalid,
    input  logic [`ICACHE_ADDR_W-1:0] araddr,
    output logic                      arready,
    output logic                      rvalid,
    output logic [`ICACHE_DATA_W-1:0] rdata,
    output logic                      rlast,
    input  logic                      rready
);

    logic [31:0]               lcg_state;
    logic [`ICACHE_ADDR_W-1:0] base;

    // zero to three idle cycles when stalls are on
    function automatic int next_stall();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return stall_en ? {30'd0, lcg_state[17:16]} : 0;
    endfunction

    task automatic wait_stall();
        int n;
        n = next_stall();
        repeat (n) @(negedge clk);
    endtask

    initial begin
        lcg_state = SEED;
        arready   = 1'b0;
        rvalid    = 1'b0;
        rdata     = '0;
        rlast     = 1'b0;
        base      = '0;
        forever begin
            @(negedge clk);
            if (rst_n && arvalid) begin
                wait_stall();
                arready = 1'b1;
                // arvalid is held, so the next edge takes the address
                @(posedge clk);
                base = araddr;
                @(negedge clk);
                arready = 1'b0;
                for (int beat = 0; beat < `ICACHE_LINE_WORDS; beat++) begin
                    wait_stall();
                    rvalid = 1'b1;
                    rdata  = (base + 32'(beat * 4)) * DATA_MULT;
                    rlast  = (beat == `ICACHE_LINE_WORDS - 1);
                    @(posedge clk);
                    while (!rready) begin
                        @(posedge clk);
                    end
                    @(negedge clk);
                    rvalid = 1'b0;
                    rlast  = 1'b0;
                    rdata  = '0;
                end
            end
        end
    end

endmodule

//--- test/tb_icache.sv
`timescale 1ns/1ps
`include "icache_defs.svh"

module tb_icache;

    localparam int          HALF_PERIOD   = 5;
    localparam int          NUM_TESTS     = 6;
    localparam int          TEST_BOUND_NS = 20000;
    localparam int          WAIT_LIMIT    = 200;
    localparam logic [31:0] DATA_MULT     = 32'h9E37_79B1;
    localparam logic [31:0] SEED          = 32'd91171;

    logic                      clk;
    logic                      rst_n;
    logic                      req_valid;
    logic [`ICACHE_ADDR_W-1:0] req_addr;
    logic                      resp_ready;
    logic                      resp_valid;
    logic [`ICACHE_DATA_W-1:0] resp_data;
    logic                      arvalid;
    logic [`ICACHE_ADDR_W-1:0] araddr;
    logic                      arready;
    logic                      rvalid;
    logic [`ICACHE_DATA_W-1:0] rdata;
    logic                      rlast;
    logic                      rready;
    logic                      stall_en;

    logic [31:0]               rand_state;
    logic [`ICACHE_ADDR_W-1:0] last_araddr;
    logic                      in_burst;
    logic                      last_beat_q;
    int                        ar_count = 0;
    int                        errors = 0;
    int                        checks = 0;
    string                     test_name = "reset";

    icache_top uut (.*);

    axi_mem_model #(.DATA_MULT(DATA_MULT), .SEED(SEED)) u_mem (.*);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        #(NUM_TESTS * TEST_BOUND_NS);
        $display("watchdog expired after %0d ns, test %s is stuck",
                 NUM_TESTS * TEST_BOUND_NS, test_name);
        $display("TEST FAIL");
        $finish;
    end

    // AR handshakes seen on the top level ports
    always @(posedge clk) begin
        if (arvalid && arready) begin
            ar_count    <= ar_count + 1;
            last_araddr <= araddr;
        end
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_burst    <= 1'b0;
            last_beat_q <= 1'b0;
        end else begin
            last_beat_q <= rvalid && rready && rlast;
            if (arvalid && arready) begin
                in_burst <= 1'b1;
            end else if (rvalid && rready && rlast) begin
                in_burst <= 1'b0;
            end
        end
    end

    // no new request may be taken while a line is still arriving
    always @(negedge clk) begin
        if (rst_n && in_burst) begin
            assert (!resp_ready) else begin
                $display("%s: resp_ready went high before the last refill beat", test_name);
                errors++;
            end
        end
        if (rst_n && last_beat_q) begin
            assert (resp_ready) else begin
                $display("%s: resp_ready still low after the last refill beat", test_name);
                errors++;
            end
        end
        // rready spans exactly the data phase
        if (rst_n) begin
            assert (rready === in_burst) else begin
                $display("Fail %s: rready expected %b actual %b", test_name, in_burst, rready);
                errors++;
            end
        end
    end

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    // memory word is its byte address times an odd constant
    function automatic logic [31:0] model_word(input logic [31:0] a);
        return {a[31:2], 2'b00} * DATA_MULT;
    endfunction

    function automatic logic [31:0] make_addr(input logic [`ICACHE_TAG_W-1:0] tag,
                                              input logic [`ICACHE_INDEX_W-1:0] idx,
                                              input logic [`ICACHE_WOFS_W-1:0] wofs);
        return {tag, idx, wofs, 2'b00};
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("Fail %s: %s expected %h actual %h", test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst_n = 1'b0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
    endtask

    // one request, returns the word and the edges from acceptance to resp_valid
    task automatic fetch(input logic [31:0] a, output logic [31:0] data, output int edges);
        int wait_cycles;
        wait_cycles = 0;
        edges = 0;
        while (!resp_ready && wait_cycles < WAIT_LIMIT) begin
            @(negedge clk);
            wait_cycles++;
        end
        assert (resp_ready) else begin
            $display("%s: cache never became ready for address %h", test_name, a);
            errors++;
        end
        req_valid = 1'b1;
        req_addr  = a;
        @(posedge clk);
        @(negedge clk);
        req_valid = 1'b0;
        req_addr  = ~a;
        while (!resp_valid && edges < WAIT_LIMIT) begin
            @(negedge clk);
            edges++;
        end
        assert (resp_valid) else begin
            $display("%s: no response for address %h", test_name, a);
            errors++;
        end
        data = resp_data;
    endtask

    task automatic fetch_check(input logic [31:0] a, input logic expect_hit);
        int          ar_before;
        int          edges;
        logic [31:0] data;
        ar_before = ar_count;
        fetch(a, data, edges);
        check_value("instruction word", model_word(a), data);
        if (expect_hit) begin
            check_value("response edges", 32'd2, edges);
            check_value("AR handshakes", 32'd0, ar_count - ar_before);
        end else begin
            check_value("AR handshakes", 32'd1, ar_count - ar_before);
            check_value("AR address", {a[31:5], 5'b00000}, last_araddr);
        end
    endtask

    task automatic test_cold_miss();
        test_name = "cold_miss";
        fetch_check(make_addr(23'h0001A2, 4'd3, 3'd5), 1'b0);
    endtask

    task automatic test_hit_timing();
        test_name = "hit_timing";
        for (int w = 0; w < `ICACHE_LINE_WORDS; w++) begin
            fetch_check(make_addr(23'h0001A2, 4'd3, w[2:0]), 1'b1);
        end
    endtask

    task automatic test_two_ways();
        test_name = "two_ways";
        fetch_check(make_addr(23'h000011, 4'd9, 3'd1), 1'b0);
        fetch_check(make_addr(23'h000022, 4'd9, 3'd6), 1'b0);
        fetch_check(make_addr(23'h000022, 4'd9, 3'd0), 1'b1);
        fetch_check(make_addr(23'h000011, 4'd9, 3'd4), 1'b1);
        fetch_check(make_addr(23'h000022, 4'd9, 3'd3), 1'b1);
        fetch_check(make_addr(23'h000011, 4'd9, 3'd7), 1'b1);
    endtask

    // third tag takes the way filled first, then the victim bit points at the other
    task automatic test_round_robin();
        test_name = "round_robin";
        fetch_check(make_addr(23'h000033, 4'd9, 3'd2), 1'b0);
        fetch_check(make_addr(23'h000022, 4'd9, 3'd5), 1'b1);
        fetch_check(make_addr(23'h000011, 4'd9, 3'd1), 1'b0);
        fetch_check(make_addr(23'h000033, 4'd9, 3'd6), 1'b1);
    endtask

    task automatic test_back_pressure();
        logic [31:0] a;
        test_name = "back_pressure";
        stall_en = 1'b1;
        for (int i = 0; i < 8; i++) begin
            a = next_rand();
            // unique tag per pass so every fetch misses
            a[31:24] = {4'hC, i[3:0]};
            fetch_check(a, 1'b0);
        end
        stall_en = 1'b0;
    endtask

    task automatic test_reset_clears();
        test_name = "reset_clears";
        fetch_check(make_addr(23'h0055A5, 4'd12, 3'd2), 1'b0);
        fetch_check(make_addr(23'h0055A5, 4'd12, 3'd2), 1'b1);
        apply_reset();
        fetch_check(make_addr(23'h0055A5, 4'd12, 3'd2), 1'b0);
    endtask

    initial begin
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        req_addr   = '0;
        stall_en   = 1'b0;
        rand_state = SEED;
        apply_reset();
        test_cold_miss();
        test_hit_timing();
        test_two_ways();
        test_round_robin();
        test_back_pressure();
        test_reset_clears();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+design
design/icache_pkg.sv
design/icache_tag_array.sv
design/icache_data_array.sv
design/icache_refill.sv
design/icache_ctrl.sv
design/icache_top.sv
test/axi_mem_model.sv
test/tb_icache.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_icache -f project.f \
    -o sim_icache > build.log 2>&1 \
    || { cat build.log; echo "verilator build failed"; exit 1; }
./obj_dir/sim_icache > sim.log 2>&1
cat sim.log
grep -q "TEST FAIL" sim.log && exit 1
grep -q "TEST PASS" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0
